//--- logic/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// datapath width, also used for load/store addresses.
`define CORE_XLEN 32

// destination register number width.
`define CORE_REG_AW 5

`define CORE_PC_W 32 // program counter width.

// private data memory depth, counted in 32-bit words.
`define CORE_DMEM_WORDS 256

`endif

//--- logic/core_pkg.sv
`include "core_defs.svh"

package core_pkg;

    // operations that reach the back end after decode.
    typedef enum logic [3:0] {
        ADD = 4'd0,
        SUB = 4'd1,
        AND = 4'd2,
        OR  = 4'd3,
        XOR = 4'd4,
        SLT = 4'd5, // signed compare, result is 1 or 0.
        LB  = 4'd6,
        LBU = 4'd7,
        LH  = 4'd8,
        LHU = 4'd9,
        LW  = 4'd10,
        SB  = 4'd11,
        SH  = 4'd12,
        SW  = 4'd13
    } op_e;

    // payload handed from one pipeline stage to the next.
    typedef struct packed {
        op_e                     op;
        logic [`CORE_REG_AW-1:0] rd;
        logic                    rd_en;      // clear for stores and for x0.
        logic [`CORE_XLEN-1:0]   result;     // alu result or effective address.
        logic [`CORE_XLEN-1:0]   store_data;
        logic [`CORE_PC_W-1:0]   pc;
    } stage_t;

endpackage

//--- logic/mem_pkg.sv
`include "core_defs.svh"

package mem_pkg;

    // width of a data memory access.
    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } ls_size_e;

    // record presented at the write-back port.
    typedef struct packed {
        logic [`CORE_REG_AW-1:0] rd;
        logic                    rd_en;
        logic [`CORE_XLEN-1:0]   data; // load data, alu result or store address.
        logic [`CORE_PC_W-1:0]   pc;
    } wb_t;

endpackage

//--- logic/stage_if.sv
`timescale 1ns/10ps

// one pipeline stage boundary: a valid bit and the instruction payload.
interface stage_if;

    logic             valid;
    core_pkg::stage_t payload;

    // the producing stage.
    modport src (
        output valid,
        output payload
    );

    // the consuming stage.
    modport dst (
        input valid,
        input payload
    );

endinterface

//--- logic/execute_unit.sv
`timescale 1ns/10ps
`include "core_defs.svh"

module execute_unit (
    input  logic                    issue_valid_i,
    input  core_pkg::op_e           issue_op_i,
    input  logic [`CORE_XLEN-1:0]   issue_rs1_i,
    input  logic [`CORE_XLEN-1:0]   issue_rs2_i,
    input  logic [`CORE_XLEN-1:0]   issue_imm_i,
    input  logic [`CORE_REG_AW-1:0] issue_rd_i,
    input  logic [`CORE_PC_W-1:0]   issue_pc_i,
    stage_if.src                    ex_o
);

    logic [`CORE_XLEN-1:0] eff_addr;
    logic                  less_than;
    logic                  writes_rd;
    core_pkg::stage_t      ex_d;

    assign eff_addr  = issue_rs1_i + issue_imm_i; // loads and stores use base plus offset.
    assign less_than = $signed(issue_rs1_i) < $signed(issue_rs2_i);

    always_comb begin
        ex_d      = '0;
        writes_rd = 1'b0;
        ex_d.op   = issue_op_i;
        ex_d.rd   = issue_rd_i;
        ex_d.pc   = issue_pc_i;
        case (issue_op_i)
            core_pkg::ADD: begin
                ex_d.result = issue_rs1_i + issue_rs2_i;
                writes_rd   = 1'b1;
            end
            core_pkg::SUB: begin
                ex_d.result = issue_rs1_i - issue_rs2_i;
                writes_rd   = 1'b1;
            end
            core_pkg::AND: begin
                ex_d.result = issue_rs1_i & issue_rs2_i;
                writes_rd   = 1'b1;
            end
            core_pkg::OR: begin
                ex_d.result = issue_rs1_i | issue_rs2_i;
                writes_rd   = 1'b1;
            end
            core_pkg::XOR: begin
                ex_d.result = issue_rs1_i ^ issue_rs2_i;
                writes_rd   = 1'b1;
            end
            core_pkg::SLT: begin
                ex_d.result = {{(`CORE_XLEN-1){1'b0}}, less_than};
                writes_rd   = 1'b1;
            end
            core_pkg::LB, core_pkg::LBU, core_pkg::LH, core_pkg::LHU, core_pkg::LW: begin
                ex_d.result     = eff_addr;
                ex_d.store_data = issue_rs2_i;
                writes_rd       = 1'b1;
            end
            core_pkg::SB, core_pkg::SH, core_pkg::SW: begin
                ex_d.result     = eff_addr;
                ex_d.store_data = issue_rs2_i;
            end
            default: ex_d.result = '0;
        endcase
        // x0 is never written, so the enable drops here once for the whole back end.
        ex_d.rd_en = writes_rd && (issue_rd_i != '0);
    end

    always_comb begin
        if (issue_valid_i) begin
            assert (issue_op_i inside {[core_pkg::ADD:core_pkg::SW]})
                else $error("execute_unit: illegal op %0d issued", issue_op_i);
        end
    end

    assign ex_o.valid   = issue_valid_i;
    assign ex_o.payload = ex_d;

endmodule

//--- logic/ex_mem_reg.sv
`timescale 1ns/10ps

module ex_mem_reg (
    input  logic clk,
    input  logic arst_n_i,
    input  logic stall_i,
    stage_if.dst ex_i,
    stage_if.src mem_o
);

    logic             valid_q;
    core_pkg::stage_t payload_q;

    // hold under stall so the memory stage sees the same instruction until it may proceed.
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q   <= 1'b0;
            payload_q <= '0;
        end else if (stall_i) begin
            valid_q   <= valid_q;
            payload_q <= payload_q;
        end else begin
            valid_q   <= ex_i.valid;
            payload_q <= ex_i.payload;
        end
    end

    assign mem_o.valid   = valid_q;
    assign mem_o.payload = payload_q;

    // the issue side keeps its instruction through a stall, so nothing is lost when it ends.
    a_hold_on_stall : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        stall_i |=> ($stable(ex_i.valid) && $stable(ex_i.payload))
    ) else $error("ex_mem_reg: execute stage changed its instruction during a stall");

endmodule

//--- logic/mem_access_unit.sv
`timescale 1ns/10ps
`include "core_defs.svh"

module mem_access_unit (
    input  logic        clk,
    input  logic        arst_n_i,
    input  logic        stall_i,
    stage_if.dst        mem_i,
    output mem_pkg::wb_t wb_o,
    output logic        wb_valid_o
);

    localparam int IDX_W = $clog2(`CORE_DMEM_WORDS);

    logic [`CORE_XLEN-1:0] dmem [`CORE_DMEM_WORDS] = '{default: '0};

    logic [`CORE_XLEN-1:0] addr;
    logic [IDX_W-1:0]      word_idx;
    logic [1:0]            byte_off;
    logic [`CORE_XLEN-1:0] rdata;
    logic [`CORE_XLEN-1:0] wdata;
    logic [`CORE_XLEN-1:0] wb_data;
    logic [7:0]            byte_sel;
    logic [15:0]           half_sel;
    logic                  is_load;
    logic                  is_store;
    mem_pkg::ls_size_e     size;

    assign addr     = mem_i.payload.result;
    assign word_idx = addr[IDX_W+1:2]; // upper address bits wrap modulo the depth.
    assign byte_off = addr[1:0];
    assign rdata    = dmem[word_idx];
    assign byte_sel = rdata[{byte_off, 3'b000} +: 8];
    assign half_sel = rdata[{byte_off[1], 4'b0000} +: 16];

    assign is_load  = mem_i.payload.op inside {core_pkg::LB, core_pkg::LBU, core_pkg::LH,
                                               core_pkg::LHU, core_pkg::LW};
    assign is_store = mem_i.payload.op inside {core_pkg::SB, core_pkg::SH, core_pkg::SW};

    always_comb begin
        case (mem_i.payload.op)
            core_pkg::LB, core_pkg::LBU, core_pkg::SB: size = mem_pkg::BYTE;
            core_pkg::LH, core_pkg::LHU, core_pkg::SH: size = mem_pkg::HALF;
            default:                                   size = mem_pkg::WORD;
        endcase
    end

    // read-modify-write so bytes outside the access keep their value.
    always_comb begin
        wdata = rdata;
        case (size)
            mem_pkg::BYTE: wdata[{byte_off, 3'b000} +: 8]     = mem_i.payload.store_data[7:0];
            mem_pkg::HALF: wdata[{byte_off[1], 4'b0000} +: 16] = mem_i.payload.store_data[15:0];
            default:       wdata = mem_i.payload.store_data;
        endcase
    end

    always_comb begin
        case (mem_i.payload.op)
            core_pkg::LB:  wb_data = {{(`CORE_XLEN-8){byte_sel[7]}}, byte_sel};
            core_pkg::LBU: wb_data = {{(`CORE_XLEN-8){1'b0}}, byte_sel};
            core_pkg::LH:  wb_data = {{(`CORE_XLEN-16){half_sel[15]}}, half_sel};
            core_pkg::LHU: wb_data = {{(`CORE_XLEN-16){1'b0}}, half_sel};
            core_pkg::LW:  wb_data = rdata;
            default:       wb_data = mem_i.payload.result; // alu ops and stores pass through.
        endcase
    end

    always_ff @(posedge clk) begin
        if (mem_i.valid && is_store && !stall_i) begin
            dmem[word_idx] <= wdata;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_valid_o <= 1'b0;
            wb_o       <= '0;
        end else if (stall_i) begin
            wb_valid_o <= wb_valid_o;
            wb_o       <= wb_o;
        end else begin
            wb_valid_o <= mem_i.valid;
            wb_o.rd    <= mem_i.payload.rd;
            wb_o.rd_en <= mem_i.payload.rd_en;
            wb_o.data  <= wb_data;
            wb_o.pc    <= mem_i.payload.pc;
        end
    end

    a_half_aligned : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (mem_i.valid && (is_load || is_store) && size == mem_pkg::HALF) |-> !addr[0]
    ) else $error("mem_access_unit: misaligned halfword access at %h", addr);

    a_word_aligned : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (mem_i.valid && (is_load || is_store) && size == mem_pkg::WORD) |-> (addr[1:0] == 2'b00)
    ) else $error("mem_access_unit: misaligned word access at %h", addr);

endmodule

//--- logic/backend_top.sv
`timescale 1ns/10ps
`include "core_defs.svh"

module backend_top (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic                    issue_valid_i,
    input  core_pkg::op_e           issue_op_i,
    input  logic [`CORE_XLEN-1:0]   issue_rs1_i,
    input  logic [`CORE_XLEN-1:0]   issue_rs2_i,
    input  logic [`CORE_XLEN-1:0]   issue_imm_i,
    input  logic [`CORE_REG_AW-1:0] issue_rd_i,
    input  logic [`CORE_PC_W-1:0]   issue_pc_i,
    input  logic                    stall_i,
    output logic                    wb_valid_o,
    output logic [`CORE_REG_AW-1:0] wb_rd_o,
    output logic                    wb_rd_en_o,
    output logic [`CORE_XLEN-1:0]   wb_data_o,
    output logic [`CORE_PC_W-1:0]   wb_pc_o
);

    stage_if ex_bus ();
    stage_if mem_bus ();

    mem_pkg::wb_t wb;

    execute_unit u_execute (
        .issue_valid_i (issue_valid_i),
        .issue_op_i    (issue_op_i),
        .issue_rs1_i   (issue_rs1_i),
        .issue_rs2_i   (issue_rs2_i),
        .issue_imm_i   (issue_imm_i),
        .issue_rd_i    (issue_rd_i),
        .issue_pc_i    (issue_pc_i),
        .ex_o          (ex_bus.src)
    );

    ex_mem_reg u_ex_mem (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .stall_i  (stall_i),
        .ex_i     (ex_bus.dst),
        .mem_o    (mem_bus.src)
    );

    mem_access_unit u_mem_access (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .stall_i    (stall_i),
        .mem_i      (mem_bus.dst),
        .wb_o       (wb),
        .wb_valid_o (wb_valid_o)
    );

    // flatten the write-back record onto the plain output ports.
    assign wb_rd_o    = wb.rd;
    assign wb_rd_en_o = wb.rd_en;
    assign wb_data_o  = wb.data;
    assign wb_pc_o    = wb.pc;

endmodule

//--- verification/clock_gen.sv
`timescale 1ns/10ps

module clock_gen (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o; // 10 ns period.
    end

    // reset covers 16 rising edges and is released between edges.
    initial begin
        arst_n_o = 1'b0;
        repeat (16) @(posedge clk_o);
        #2 arst_n_o = 1'b1;
    end

endmodule

//--- verification/tb_backend.sv
`timescale 1ns/10ps
`include "core_defs.svh"

module tb_backend;

    typedef struct packed {
        core_pkg::op_e           op;
        logic [`CORE_XLEN-1:0]   rs1;
        logic [`CORE_XLEN-1:0]   rs2;
        logic [`CORE_XLEN-1:0]   imm;
        logic [`CORE_REG_AW-1:0] rd;
        logic [`CORE_PC_W-1:0]   pc;
        logic [`CORE_XLEN-1:0]   data;
        int                      line;
    } vec_t;

    logic                    clk;
    logic                    arst_n;
    logic                    issue_valid;
    core_pkg::op_e           issue_op;
    logic [`CORE_XLEN-1:0]   issue_rs1;
    logic [`CORE_XLEN-1:0]   issue_rs2;
    logic [`CORE_XLEN-1:0]   issue_imm;
    logic [`CORE_REG_AW-1:0] issue_rd;
    logic [`CORE_PC_W-1:0]   issue_pc;
    logic                    stall;
    logic                    wb_valid;
    logic                    wb_rd_en;
    logic [`CORE_REG_AW-1:0] wb_rd;
    logic [`CORE_XLEN-1:0]   wb_data;
    logic [`CORE_PC_W-1:0]   wb_pc;
    mem_pkg::wb_t            wb_act;

    vec_t         vecs[$];
    mem_pkg::wb_t exp_q[$];
    int           due_q[$];   // edge count minus stalled edges at which the result is due.
    int           line_q[$];
    int           mismatch_cnt = 0;
    int           other_cnt = 0;
    int           edge_cnt = 0;
    int           stall_cnt = 0;
    int           idx = 0;
    logic         last_stall = 1'b0;
    logic         idle_checked = 1'b0;
    logic [31:0]  lfsr = 32'hdb6b;

    clock_gen u_clock_gen (.clk_o(clk), .arst_n_o(arst_n));

    backend_top DUT (
        .clk           (clk),
        .arst_n_i      (arst_n),
        .issue_valid_i (issue_valid),
        .issue_op_i    (issue_op),
        .issue_rs1_i   (issue_rs1),
        .issue_rs2_i   (issue_rs2),
        .issue_imm_i   (issue_imm),
        .issue_rd_i    (issue_rd),
        .issue_pc_i    (issue_pc),
        .stall_i       (stall),
        .wb_valid_o    (wb_valid),
        .wb_rd_o       (wb_rd),
        .wb_rd_en_o    (wb_rd_en),
        .wb_data_o     (wb_data),
        .wb_pc_o       (wb_pc)
    );

    assign wb_act = {wb_rd, wb_rd_en, wb_data, wb_pc};

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // two bits per draw, so a stall comes about one cycle in four.
    function automatic logic draw_stall();
        logic a;
        lfsr = lfsr_next(lfsr);
        a = lfsr[0];
        lfsr = lfsr_next(lfsr);
        return a & lfsr[0];
    endfunction

    function automatic int op_code(string s);
        core_pkg::op_e o;
        o = o.first();
        for (int i = 0; i < o.num(); i++) begin
            if (o.name() == s) return int'(o);
            o = o.next();
        end
        return -1;
    endfunction

    task automatic load_vectors();
        int fd;
        int line_no;
        int n;
        int code;
        string line_s;
        string op_s;
        logic [31:0] rs1, rs2, imm, pc, data;
        logic [`CORE_REG_AW-1:0] rd;
        vec_t v;
        fd = $fopen("verification/backend_input.txt", "r");
        if (fd == 0) begin
            other_cnt++;
            $display("cannot open verification/backend_input.txt");
            return;
        end
        line_no = 0;
        while ($fgets(line_s, fd) != 0) begin
            line_no++;
            n = $sscanf(line_s, "%s %h %h %h %h %h %h", op_s, rs1, rs2, imm, rd, pc, data);
            if (n < 1) continue;
            if (op_s.substr(0, 0) == "#") continue; // column legend.
            code = op_code(op_s);
            if (n != 7 || code < 0) begin
                other_cnt++;
                $display("line %0d of the input file cannot be read", line_no);
                continue;
            end
            v = '{core_pkg::op_e'(code[3:0]), rs1, rs2, imm, rd, pc, data, line_no};
            vecs.push_back(v);
        end
        $fclose(fd);
        if (vecs.size() == 0) begin
            other_cnt++;
            $display("the input file holds no instructions");
        end
    endtask

    task automatic check_wb(string name, mem_pkg::wb_t exp, mem_pkg::wb_t act);
        string exp_s;
        string act_s;
        if (act !== exp) begin
            mismatch_cnt++;
            exp_s = $sformatf("rd=%0d rd_en=%0b data=%h pc=%h",
                              exp.rd, exp.rd_en, exp.data, exp.pc);
            act_s = $sformatf("rd=%0d rd_en=%0b data=%h pc=%h",
                              act.rd, act.rd_en, act.data, act.pc);
            $display("Mismatch %s: expected %s actual %s", name, exp_s, act_s);
        end
    endtask

    task automatic check_idle(string name, logic exp, logic act);
        if (act !== exp) begin
            mismatch_cnt++;
            $display("Mismatch %s: expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_cycle(string name, int exp, int act);
        if (act != exp) begin
            mismatch_cnt++;
            $display("Mismatch %s latency: expected slot %0d actual slot %0d", name, exp, act);
        end
    endtask

    task automatic finish_run();
        if (exp_q.size() != 0) begin
            other_cnt++;
            $display("%0d write-back results never arrived", exp_q.size());
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    initial begin
        vec_t v;
        mem_pkg::wb_t e;
        issue_valid = 1'b0;
        issue_op    = core_pkg::ADD;
        issue_rs1   = '0;
        issue_rs2   = '0;
        issue_imm   = '0;
        issue_rd    = '0;
        issue_pc    = '0;
        stall       = 1'b0;
        load_vectors();
        @(posedge arst_n);
        while (idx < vecs.size() || issue_valid || exp_q.size() != 0) begin
            @(posedge clk);
            edge_cnt++;
            if (stall) begin
                stall_cnt++; // inputs stay as they are.
            end else begin
                if (issue_valid) begin
                    v = vecs[idx];
                    e.rd    = v.rd;
                    e.rd_en = !(v.op inside {core_pkg::SB, core_pkg::SH, core_pkg::SW})
                              && (v.rd != '0);
                    e.data  = v.data;
                    e.pc    = v.pc;
                    exp_q.push_back(e);
                    due_q.push_back(edge_cnt - stall_cnt + 1);
                    line_q.push_back(v.line);
                    idx++;
                end
                if (idx < vecs.size()) begin
                    issue_valid <= 1'b1;
                    issue_op    <= vecs[idx].op;
                    issue_rs1   <= vecs[idx].rs1;
                    issue_rs2   <= vecs[idx].rs2;
                    issue_imm   <= vecs[idx].imm;
                    issue_rd    <= vecs[idx].rd;
                    issue_pc    <= vecs[idx].pc;
                end else begin
                    issue_valid <= 1'b0;
                end
            end
            last_stall = stall;
            stall <= draw_stall();
        end
        finish_run();
    end

    // a new write-back result appears only after an edge that was not stalled.
    always @(negedge clk) begin
        string name;
        if (!arst_n || !idle_checked) begin
            check_idle("reset wb_valid_o", 1'b0, wb_valid);
            check_idle("reset wb_rd_en_o", 1'b0, wb_rd_en);
            idle_checked = arst_n;
        end else if (wb_valid && !last_stall) begin
            if (exp_q.size() == 0) begin
                other_cnt++;
                $display("write-back at pc %h with no instruction outstanding", wb_pc);
            end else begin
                name = $sformatf("line %0d", line_q.pop_front());
                check_wb(name, exp_q.pop_front(), wb_act);
                check_cycle(name, due_q.pop_front(), edge_cnt - stall_cnt);
            end
        end
    end

    initial begin
        int limit;
        int cycle_cnt;
        @(posedge clk);
        limit = 16 + 4 * vecs.size() + 20;
        cycle_cnt = 1;
        while (cycle_cnt < limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        other_cnt++;
        $display("timeout after %0d cycles", cycle_cnt);
        finish_run();
    end

endmodule

//--- verification/backend_input.txt
# op  rs1      rs2      imm      rd pc       expected write-back data (hex)
# stores expect their effective address, since it passes through as data.
ADD 00000005 00000003 00000000 01 00001000 00000008
SUB 00000005 00000007 00000000 02 00001004 fffffffe
AND f0f0f0f0 ff00ff00 00000000 03 00001008 f000f000
OR  f0f0f0f0 0f0f0f0f 00000000 04 0000100c ffffffff
XOR aaaa5555 ffff0000 00000000 05 00001010 55555555
SLT ffffffff 00000001 00000000 06 00001014 00000001
SLT 00000001 ffffffff 00000000 07 00001018 00000000
ADD 00000010 00000020 00000000 00 0000101c 00000030
SW  00000100 12345678 00000010 08 00001020 00000110
LW  00000100 00000000 00000010 09 00001024 12345678
SW  00000200 11223344 00000000 00 00001028 00000200
SB  00000200 000000a5 00000001 00 0000102c 00000201
SH  00000200 0000f00d 00000002 00 00001030 00000202
LB  00000200 00000000 00000001 0a 00001034 ffffffa5
LBU 00000200 00000000 00000001 0b 00001038 000000a5
LB  00000200 00000000 00000000 0c 0000103c 00000044
LH  00000200 00000000 00000002 0d 00001040 fffff00d
LHU 00000200 00000000 00000002 0e 00001044 0000f00d
LW  00000200 00000000 00000000 0f 00001048 f00da544
LBU 00000200 00000000 00000003 10 0000104c 000000f0
LW  00000100 00000000 00000010 11 00001050 12345678

//--- all.f
+incdir+logic
logic/core_pkg.sv
logic/mem_pkg.sv
logic/stage_if.sv
logic/execute_unit.sv
logic/ex_mem_reg.sv
logic/mem_access_unit.sv
logic/backend_top.sv
verification/clock_gen.sv
verification/tb_backend.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"
mkdir -p build
verilator --binary --timing --assert -sv -f all.f --top-module tb_backend \
    -Mdir build/obj_dir -o sim_backend
./build/obj_dir/sim_backend | tee build/sim.log
if grep -q "Regression failed" build/sim.log; then
    exit 1
fi
